// File: files.f
common/core_pkg.sv
hdl/ifu.sv
idu/idu.sv
hdl/regfile.sv
hdl/exu.sv
hdl/core_top.sv
tb/core_properties.sv
tb/core_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module core_tb \
    -f files.f -o core_sim

./obj_dir/core_sim | tee sim.log

if grep -qx "Done: no errors" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

// File: tb/core_tb.sv
module core_tb;
    import core_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 10;
    localparam int RESET_CYCLES = 16;
    localparam int PROG_BITS    = 6;
    localparam int PROG_LEN     = 1 << PROG_BITS;
    localparam int RANDOM_COUNT = 24;
    localparam int HOLD_CYCLES  = 8;
    localparam int CYCLE_LIMIT  = PROG_LEN + RESET_CYCLES + 50;

    localparam word_t EBREAK_WORD = {12'h001, 5'd0, 3'b000, 5'd0, OP_SYSTEM};

    typedef struct packed {
        logic      wen;
        reg_addr_t addr;
        word_t     data;
        logic      halt;
    } expect_t;

    logic      clk;
    logic      reset;
    word_t     inst = '0;
    word_t     pc;
    logic      wb_en;
    reg_addr_t wb_addr;
    word_t     wb_data;
    logic      halted;

    word_t prog [PROG_LEN] = '{default: '0};
    word_t model_regs [32] = '{default: '0};
    word_t model_pc = RESET_PC;
    logic  model_halted = 1'b0;
    int    hold_count = 0;
    int    seed;
    int    cycle_count = 0;
    int    mismatch_count = 0;
    int    failure_count = 0;
    logic  test_done = 1'b0;
    logic  timed_out = 1'b0;

    core_top u_dut (
        .clk     (clk),
        .reset   (reset),
        .inst    (inst),
        .pc      (pc),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data),
        .halted  (halted)
    );

    bind core_top core_properties u_props (
        .clk    (clk),
        .reset  (reset),
        .pc     (pc),
        .wb_en  (wb_en),
        .halted (halted)
    );

    function automatic word_t imm_op_word(input logic [2:0] funct3, input reg_addr_t rd,
                                          input reg_addr_t rs1, input logic [11:0] imm);
        return {imm, rs1, funct3, rd, OP_IMM};
    endfunction

    function automatic word_t upper_word(input logic [6:0] op, input reg_addr_t rd,
                                         input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    // anything outside the program image reads as an all-zero word, which is no instruction.
    function automatic word_t fetch_word(input word_t addr);
        word_t offset;
        offset = (addr - RESET_PC) >> 2;
        if (offset < PROG_LEN) begin
            return prog[offset[PROG_BITS-1:0]];
        end
        return '0;
    endfunction

    function automatic expect_t expected_result(input word_t ins, input word_t pc_val,
                                                input word_t regs [32]);
        expect_t e;
        word_t   imm_i;
        word_t   imm_u;
        e     = '0;
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_u = {ins[31:12], 12'h000};
        if ((ins[6:0] == OP_IMM) && (ins[14:12] == 3'b000)) begin
            e.wen  = 1'b1;
            e.addr = ins[11:7];
            e.data = regs[ins[19:15]] + imm_i;
        end else if (ins[6:0] == OP_LUI) begin
            e.wen  = 1'b1;
            e.addr = ins[11:7];
            e.data = imm_u;
        end else if (ins[6:0] == OP_AUIPC) begin
            e.wen  = 1'b1;
            e.addr = ins[11:7];
            e.data = pc_val + imm_u;
        end else if (ins == EBREAK_WORD) begin
            e.halt = 1'b1;
        end
        return e;
    endfunction

    task automatic build_program();
        logic [PROG_BITS-1:0] n;
        word_t                r;
        n = '0;
        // chained addi through x1 and x2 with negative immediates.
        prog[n++] = imm_op_word(3'b000, 5'd1, 5'd0, 12'h7ff);
        prog[n++] = imm_op_word(3'b000, 5'd1, 5'd1, 12'hffe);
        prog[n++] = imm_op_word(3'b000, 5'd2, 5'd1, 12'h800);
        prog[n++] = imm_op_word(3'b000, 5'd2, 5'd2, 12'hfff);
        prog[n++] = upper_word(OP_LUI, 5'd3, 20'hdead1);
        prog[n++] = upper_word(OP_AUIPC, 5'd4, 20'h00012);
        prog[n++] = upper_word(OP_LUI, 5'd5, 20'hfffff);
        prog[n++] = imm_op_word(3'b000, 5'd5, 5'd5, 12'h801);
        // x0 must stay zero after these writes.
        prog[n++] = imm_op_word(3'b000, 5'd0, 5'd1, 12'h123);
        prog[n++] = upper_word(OP_LUI, 5'd0, 20'h55555);
        prog[n++] = imm_op_word(3'b000, 5'd6, 5'd0, 12'h9ab);
        // slti, ori and an R-type add are outside the set and retire as nop.
        prog[n++] = imm_op_word(3'b010, 5'd7, 5'd1, 12'h004);
        prog[n++] = imm_op_word(3'b110, 5'd8, 5'd2, 12'h0f0);
        prog[n++] = 32'h0020_81b3;
        repeat (RANDOM_COUNT) begin
            r = $random(seed);
            case (r[1:0])
                2'd2:    prog[n++] = upper_word(OP_LUI, r[11:7], r[31:12]);
                2'd3:    prog[n++] = upper_word(OP_AUIPC, r[11:7], r[31:12]);
                default: prog[n++] = imm_op_word(3'b000, r[11:7], r[19:15], r[31:20]);
            endcase
        end
        prog[n++] = EBREAK_WORD;
        prog[n++] = imm_op_word(3'b000, 5'd9, 5'd1, 12'h001);
    endtask

    task automatic report_mismatch(input string name, input word_t got, input word_t want);
        $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, want);
        mismatch_count++;
    endtask

    task automatic check_cycle();
        word_t   ins;
        expect_t want;
        ins  = fetch_word(model_pc);
        want = expected_result(ins, model_pc, model_regs);
        // a halted core retires nothing.
        if (model_halted) begin
            want.wen = 1'b0;
        end
        if (pc !== model_pc) begin
            report_mismatch("pc", pc, model_pc);
        end
        if (halted !== model_halted) begin
            report_mismatch("halted", word_t'(halted), word_t'(model_halted));
        end
        if (wb_en !== want.wen) begin
            report_mismatch("wb_en", word_t'(wb_en), word_t'(want.wen));
        end
        if (want.wen && (wb_addr !== want.addr)) begin
            report_mismatch("wb_addr", word_t'(wb_addr), word_t'(want.addr));
        end
        if (want.wen && (wb_data !== want.data)) begin
            report_mismatch("wb_data", wb_data, want.data);
        end
        if (want.wen && (want.addr != 5'd0)) begin
            model_regs[want.addr] = want.data;
        end
        if (!model_halted) begin
            model_pc = model_pc + 32'd4;
        end
        if (want.halt) begin
            model_halted = 1'b1;
        end
        if (model_halted) begin
            hold_count++;
            if (hold_count > HOLD_CYCLES) begin
                test_done = 1'b1;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    always @(posedge clk) begin
        #DRIVE_DELAY;
        inst = fetch_word(pc);
    end

    // outputs are compared mid-cycle, long after the inputs have settled.
    always @(negedge clk) begin
        if (!reset && !test_done) begin
            check_cycle();
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            timed_out <= 1'b1;
        end
    end

    initial begin
        reset = 1'b1;
        seed  = 32'haf3;
        build_program();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        while (!test_done && !timed_out) begin
            @(posedge clk);
        end
        if (!test_done) begin
            $display("Timeout: the core did not halt within %0d cycles", CYCLE_LIMIT);
            failure_count++;
        end
        $display("Error count: %0d mismatches, %0d other failures",
                 mismatch_count, failure_count);
        if ((mismatch_count == 0) && (failure_count == 0)) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: tb/core_properties.sv
module core_properties (
    input logic            clk,
    input logic            reset,
    input core_pkg::word_t pc,
    input logic            wb_en,
    input logic            halted
);
    import core_pkg::*;

    property no_write_when_halted;
        @(posedge clk) disable iff (reset)
            halted |-> !wb_en;
    endproperty

    // the pc seen at an edge was set by the previous edge, so the cause lies one edge back.
    property pc_holds_when_halted;
        @(posedge clk) disable iff (reset)
            (!$past(reset) && $past(halted)) |-> (pc == $past(pc));
    endproperty

    property halted_is_sticky;
        @(posedge clk) disable iff (reset)
            (!$past(reset) && $past(halted)) |-> halted;
    endproperty

    property pc_steps_by_four;
        @(posedge clk) disable iff (reset)
            (!$past(reset) && !$past(halted)) |-> (pc == $past(pc) + word_t'(4));
    endproperty

    assert property (no_write_when_halted)
        else $error("wb_en is high while the core is halted");

    assert property (pc_holds_when_halted)
        else $error("pc changed after the core halted");

    assert property (halted_is_sticky)
        else $error("halted fell without a reset");

    assert property (pc_steps_by_four)
        else $error("pc did not advance by four");

endmodule

// File: hdl/core_top.sv
module core_top (
    input  logic                clk,
    input  logic                reset,
    input  core_pkg::word_t     inst,
    output core_pkg::word_t     pc,
    output logic                wb_en,
    output core_pkg::reg_addr_t wb_addr,
    output core_pkg::word_t     wb_data,
    output logic                halted
);
    import core_pkg::*;

    word_t     pc_w;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    word_t     rdata1;
    word_t     rdata2;
    word_t     src1;
    word_t     src2;
    reg_addr_t des;
    exu_cmd_t  cmd;
    logic      wb_en_w;
    reg_addr_t wb_addr_w;
    word_t     wb_data_w;
    logic      halted_w;

    ifu u_ifu (
        .clk    (clk),
        .reset  (reset),
        .halted (halted_w),
        .pc     (pc_w)
    );

    idu u_idu (
        .inst   (inst),
        .pc     (pc_w),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .src1   (src1),
        .src2   (src2),
        .des    (des),
        .cmd    (cmd)
    );

    regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .raddr1  (raddr1),
        .raddr2  (raddr2),
        .rdata1  (rdata1),
        .rdata2  (rdata2),
        .wb_en   (wb_en_w),
        .wb_addr (wb_addr_w),
        .wb_data (wb_data_w)
    );

    exu u_exu (
        .clk     (clk),
        .reset   (reset),
        .src1    (src1),
        .src2    (src2),
        .des     (des),
        .cmd     (cmd),
        .wb_en   (wb_en_w),
        .wb_addr (wb_addr_w),
        .wb_data (wb_data_w),
        .halted  (halted_w)
    );

    // the write-back strobe is exported as seen by the register file.
    assign pc      = pc_w;
    assign wb_en   = wb_en_w;
    assign wb_addr = wb_addr_w;
    assign wb_data = wb_data_w;
    assign halted  = halted_w;

endmodule

// File: hdl/exu.sv
module exu (
    input  logic                clk,
    input  logic                reset,
    input  core_pkg::word_t     src1,
    input  core_pkg::word_t     src2,
    input  core_pkg::reg_addr_t des,
    input  core_pkg::exu_cmd_t  cmd,
    output logic                wb_en,
    output core_pkg::reg_addr_t wb_addr,
    output core_pkg::word_t     wb_data,
    output logic                halted
);
    import core_pkg::*;

    logic halted_q;
    logic writes_rd;

    always_comb begin
        case (cmd)
            CMD_ADD: wb_data = src1 + src2;
            CMD_EQU: wb_data = src1;
            default: wb_data = '0;
        endcase
    end

    assign writes_rd = (cmd == CMD_ADD) || (cmd == CMD_EQU);

    // once halted, nothing more reaches the register file.
    assign wb_en   = writes_rd && !halted_q;
    assign wb_addr = des;

    always_ff @(posedge clk) begin
        if (reset) begin
            halted_q <= 1'b0;
        end else if ((cmd == CMD_HALT) && !halted_q) begin
            halted_q <= 1'b1;
        end
    end

    assign halted = halted_q;

endmodule

// File: hdl/regfile.sv
module regfile (
    input  logic                clk,
    input  logic                reset,
    input  core_pkg::reg_addr_t raddr1,
    input  core_pkg::reg_addr_t raddr2,
    output core_pkg::word_t     rdata1,
    output core_pkg::word_t     rdata2,
    input  logic                wb_en,
    input  core_pkg::reg_addr_t wb_addr,
    input  core_pkg::word_t     wb_data
);
    import core_pkg::*;

    word_t regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (wb_addr != '0)) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // x0 always reads as zero, whatever the array holds.
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: idu/idu.sv
module idu (
    input  core_pkg::word_t     inst,
    input  core_pkg::word_t     pc,
    input  core_pkg::word_t     rdata1,
    input  core_pkg::word_t     rdata2,
    output core_pkg::reg_addr_t raddr1,
    output core_pkg::reg_addr_t raddr2,
    output core_pkg::word_t     src1,
    output core_pkg::word_t     src2,
    output core_pkg::reg_addr_t des,
    output core_pkg::exu_cmd_t  cmd
);
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;

    imm_kind_t imm_kind;
    src_sel_t  src1_sel;
    src_sel_t  src2_sel;
    logic      reg1_ren;
    logic      rd_wen;
    word_t     imm;

    function automatic word_t select_operand(
        input src_sel_t sel,
        input word_t    imm_val,
        input word_t    pc_val,
        input word_t    rs1_val,
        input word_t    rs2_val
    );
        word_t operand;
        case (sel)
            SRC_IMM: operand = imm_val;
            SRC_PC:  operand = pc_val;
            SRC_RS1: operand = rs1_val;
            SRC_RS2: operand = rs2_val;
            default: operand = '0;
        endcase
        return operand;
    endfunction

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    always_comb begin
        imm_kind = IMM_N;
        cmd      = CMD_NOP;
        src1_sel = SRC_ZERO;
        src2_sel = SRC_ZERO;
        rd_wen   = 1'b0;
        case (opcode)
            OP_IMM: begin
                // only addi is implemented; other funct3 values fall through as nop.
                if (funct3 == FUNCT3_ADDI) begin
                    imm_kind = IMM_I;
                    cmd      = CMD_ADD;
                    src1_sel = SRC_IMM;
                    src2_sel = SRC_RS1;
                    rd_wen   = 1'b1;
                end
            end
            OP_LUI: begin
                imm_kind = IMM_U;
                cmd      = CMD_EQU;
                src1_sel = SRC_IMM;
                rd_wen   = 1'b1;
            end
            OP_AUIPC: begin
                imm_kind = IMM_U;
                cmd      = CMD_ADD;
                src1_sel = SRC_PC;
                src2_sel = SRC_IMM;
                rd_wen   = 1'b1;
            end
            OP_SYSTEM: begin
                if (inst == EBREAK_INST) begin
                    cmd = CMD_HALT;
                end
            end
            default: begin
                cmd = CMD_NOP;
            end
        endcase
    end

    always_comb begin
        case (imm_kind)
            IMM_I:   imm = {{20{inst[31]}}, inst[31:20]};
            IMM_U:   imm = {inst[31:12], 12'b0};
            default: imm = '0;
        endcase
    end

    // a port is read only when some operand is taken from it.
    assign reg1_ren = (src1_sel == SRC_RS1) || (src2_sel == SRC_RS1);

    // no implemented instruction reads rs2, so the second port stays on x0.
    assign raddr1 = reg1_ren ? inst[19:15] : '0;
    assign raddr2 = '0;
    assign des    = rd_wen ? inst[11:7] : '0;

    assign src1 = select_operand(src1_sel, imm, pc, rdata1, rdata2);
    assign src2 = select_operand(src2_sel, imm, pc, rdata1, rdata2);

endmodule

// File: hdl/ifu.sv
module ifu (
    input  logic            clk,
    input  logic            reset,
    input  logic            halted,
    output core_pkg::word_t pc
);
    import core_pkg::*;

    word_t pc_q;
    word_t pc_next;

    // sequential fetch only, so the next pc is always four ahead.
    assign pc_next = pc_q + word_t'(4);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= RESET_PC;
        end else if (!halted) begin
            pc_q <= pc_next;
        end
    end

    assign pc = pc_q;

endmodule

// File: common/core_pkg.sv
package core_pkg;

    localparam int XLEN = 32;
    localparam int REG_COUNT = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0] reg_addr_t;

    // the decoder picks its immediate kind and operand sources with these.
    typedef logic [1:0] imm_kind_t;
    typedef logic [2:0] src_sel_t;

    typedef enum logic [3:0] {
        CMD_NOP  = 4'd0,
        CMD_ADD  = 4'd1,
        CMD_EQU  = 4'd2,
        CMD_HALT = 4'd3
    } exu_cmd_t;

    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    localparam logic [2:0] FUNCT3_ADDI = 3'b000;
    localparam word_t EBREAK_INST = 32'h0010_0073;

    localparam imm_kind_t IMM_N = 2'd0;
    localparam imm_kind_t IMM_I = 2'd1;
    localparam imm_kind_t IMM_U = 2'd2;

    localparam src_sel_t SRC_ZERO = 3'd0;
    localparam src_sel_t SRC_IMM  = 3'd1;
    localparam src_sel_t SRC_PC   = 3'd2;
    localparam src_sel_t SRC_RS1  = 3'd3;
    localparam src_sel_t SRC_RS2  = 3'd4;

    localparam word_t RESET_PC = 32'h8000_0000;

endpackage
